// File: Makefile
TOP := tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal -f list.f --top-module core_top
	verilator --lint-only --timing -Wno-fatal -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: core_top.sv
`timescale 1ns/1ps

module core_top #(
        parameter int IMEM_AW = 6
) (
        input  logic                 clk,
        input  logic                 i_rst_n,
        input  logic                 i_prog_we,
        input  logic [IMEM_AW-1:0]   i_prog_addr,
        input  pipe_pkg::word_t      i_prog_data,
        input  logic                 i_run,
        output logic                 o_retire_valid,
        output pipe_pkg::reg_idx_t   o_retire_rd,
        output pipe_pkg::word_t      o_retire_data,
        output logic                 o_halted
);

import isa_pkg::*;
import pipe_pkg::*;

////////////////////////////////////////////////////////////
// Fetch
////////////////////////////////////////////////////////////

logic [IMEM_AW-1:0] pc;
logic               fetch_valid;
word_t              instr;
logic               halt;

fetch_unit #(
        .IMEM_AW(IMEM_AW)
) fetch_i (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_run(i_run),
        .i_halt(halt),
        .o_pc(pc),
        .o_fetch_valid(fetch_valid),
        .o_halted(o_halted)
);

// Loaded while run is low, read by fetch while running
instr_mem #(
        .IMEM_AW(IMEM_AW)
) imem_i (
        .clk(clk),
        .i_we(i_prog_we),
        .i_waddr(i_prog_addr),
        .i_raddr(pc),
        .i_wdata(i_prog_data),
        .o_rdata(instr)
);

////////////////////////////////////////////////////////////
// Decode and register read
////////////////////////////////////////////////////////////

reg_idx_t rs1;
reg_idx_t rs2;
reg_idx_t rd;
word_t    imm;
alu_op_e  alu_op;
logic     use_imm;
logic     wr_en;
word_t    rdata1;
word_t    rdata2;

decoder dec_i (
        .i_instr(instr),
        .i_valid(fetch_valid),
        .o_rs1(rs1),
        .o_rs2(rs2),
        .o_rd(rd),
        .o_imm(imm),
        .o_alu_op(alu_op),
        .o_use_imm(use_imm),
        .o_wr_en(wr_en),
        .o_halt(halt)
);

// Write port fed back from the retire outputs
register_file rf_i (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_we(o_retire_valid),
        .i_waddr(o_retire_rd),
        .i_raddr1(rs1),
        .i_raddr2(rs2),
        .i_wdata(o_retire_data),
        .o_rdata1(rdata1),
        .o_rdata2(rdata2)
);

////////////////////////////////////////////////////////////
// Execute and writeback
////////////////////////////////////////////////////////////

execute_stage ex_i (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_rs1(rs1),
        .i_rs2(rs2),
        .i_rd(rd),
        .i_rdata1(rdata1),
        .i_rdata2(rdata2),
        .i_imm(imm),
        .i_alu_op(alu_op),
        .i_use_imm(use_imm),
        .i_wr_en(wr_en),
        .o_retire_valid(o_retire_valid),
        .o_retire_rd(o_retire_rd),
        .o_retire_data(o_retire_data)
);

endmodule

// File: decoder.sv
`timescale 1ns/1ps

module decoder (
        input  pipe_pkg::word_t      i_instr,
        input  logic                 i_valid,
        output pipe_pkg::reg_idx_t   o_rs1,
        output pipe_pkg::reg_idx_t   o_rs2,
        output pipe_pkg::reg_idx_t   o_rd,
        output pipe_pkg::word_t      o_imm,
        output isa_pkg::alu_op_e     o_alu_op,
        output logic                 o_use_imm,
        output logic                 o_wr_en,
        output logic                 o_halt
);

import isa_pkg::*;
import pipe_pkg::*;

opcode_e    opcode;
logic [2:0] funct3;
logic [6:0] funct7;
logic       r_funct7_ok;

assign opcode = opcode_e'(i_instr[OPC_MSB:OPC_LSB]);
assign funct3 = i_instr[F3_MSB:F3_LSB];
assign funct7 = i_instr[F7_MSB:F7_LSB];

// Register indices straight from the word
assign o_rs1 = i_instr[RS1_MSB:RS1_LSB];
assign o_rs2 = i_instr[RS2_MSB:RS2_LSB];
assign o_rd  = i_instr[RD_MSB:RD_LSB];

// Alternate funct7 only legal for SUB, SRA is not supported
assign r_funct7_ok = (funct7 == F7_BASE) ||
                     ((funct7 == F7_ALT) && (funct3 == F3_ADD_SUB));

always_comb begin
        o_imm     = '0;
        o_alu_op  = ALU_ADD;
        o_use_imm = 1'b0;
        o_wr_en   = 1'b0;
        o_halt    = 1'b0;

        if (i_valid && (i_instr == '0)) begin
                // End of program
                o_halt = 1'b1;
        end else if (i_valid) begin
                case (opcode)
                        OPC_OP: begin
                                o_wr_en = r_funct7_ok;
                                case (funct3)
                                        F3_ADD_SUB: o_alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                                        F3_SLL:     o_alu_op = ALU_SLL;
                                        F3_SLT:     o_alu_op = ALU_SLT;
                                        F3_XOR:     o_alu_op = ALU_XOR;
                                        F3_SRL:     o_alu_op = ALU_SRL;
                                        F3_OR:      o_alu_op = ALU_OR;
                                        F3_AND:     o_alu_op = ALU_AND;
                                        // SLTU not in the subset
                                        default:    o_wr_en  = 1'b0;
                                endcase
                        end
                        OPC_OP_IMM: begin
                                // Sign-extended 12-bit immediate
                                o_imm     = {{(XLEN - 12){i_instr[31]}}, i_instr[31:IMM_I_LSB]};
                                o_use_imm = 1'b1;
                                o_wr_en   = 1'b1;
                                case (funct3)
                                        F3_ADD_SUB: o_alu_op = ALU_ADD;
                                        F3_XOR:     o_alu_op = ALU_XOR;
                                        F3_OR:      o_alu_op = ALU_OR;
                                        F3_AND:     o_alu_op = ALU_AND;
                                        // Immediate shifts and SLTI not in the subset
                                        default:    o_wr_en  = 1'b0;
                                endcase
                        end
                        OPC_LUI: begin
                                // Upper 20 bits, zeros below
                                o_imm     = {i_instr[31:IMM_U_LSB], 12'b0};
                                o_alu_op  = ALU_PASS_B;
                                o_use_imm = 1'b1;
                                o_wr_en   = 1'b1;
                        end
                        default: begin
                                // Unknown word, no write and no retire
                                o_wr_en = 1'b0;
                        end
                endcase
        end
end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
        input  logic                 clk,
        input  logic                 i_rst_n,
        input  pipe_pkg::reg_idx_t   i_rs1,
        input  pipe_pkg::reg_idx_t   i_rs2,
        input  pipe_pkg::reg_idx_t   i_rd,
        input  pipe_pkg::word_t      i_rdata1,
        input  pipe_pkg::word_t      i_rdata2,
        input  pipe_pkg::word_t      i_imm,
        input  isa_pkg::alu_op_e     i_alu_op,
        input  logic                 i_use_imm,
        input  logic                 i_wr_en,
        output logic                 o_retire_valid,
        output pipe_pkg::reg_idx_t   o_retire_rd,
        output pipe_pkg::word_t      o_retire_data
);

import isa_pkg::*;
import pipe_pkg::*;

fwd_sel_e sel_a;
fwd_sel_e sel_b;
word_t    op_a;
word_t    rs2_val;
word_t    op_b;
word_t    alu_res;

////////////////////////////////////////////////////////////
// Forwarding
////////////////////////////////////////////////////////////

// Writeback register wins for a valid, nonzero matching rd
always_comb begin
        sel_a = FROM_REGFILE;
        sel_b = FROM_REGFILE;
        if (o_retire_valid && (o_retire_rd != '0)) begin
                if (o_retire_rd == i_rs1) begin
                        sel_a = FROM_WB;
                end
                if (o_retire_rd == i_rs2) begin
                        sel_b = FROM_WB;
                end
        end
end

assign op_a    = (sel_a == FROM_WB) ? o_retire_data : i_rdata1;
assign rs2_val = (sel_b == FROM_WB) ? o_retire_data : i_rdata2;

// Immediate replaces rs2 for I-type and LUI
assign op_b = i_use_imm ? i_imm : rs2_val;

////////////////////////////////////////////////////////////
// ALU
////////////////////////////////////////////////////////////

always_comb begin
        case (i_alu_op)
                ALU_ADD:    alu_res = op_a + op_b;
                ALU_SUB:    alu_res = op_a - op_b;
                ALU_AND:    alu_res = op_a & op_b;
                ALU_OR:     alu_res = op_a | op_b;
                ALU_XOR:    alu_res = op_a ^ op_b;
                // Shift by low five bits only
                ALU_SLL:    alu_res = op_a << op_b[SHAMT_W-1:0];
                ALU_SRL:    alu_res = op_a >> op_b[SHAMT_W-1:0];
                // Signed compare
                ALU_SLT:    alu_res = {{(XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
                ALU_PASS_B: alu_res = op_b;
                default:    alu_res = '0;
        endcase
end

////////////////////////////////////////////////////////////
// Writeback register
////////////////////////////////////////////////////////////

// Valid bit, one retire per written instruction
always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
                o_retire_valid <= 1'b0;
        end else begin
                o_retire_valid <= i_wr_en;
        end
end

// Result and destination
always_ff @(posedge clk) begin
        o_retire_rd   <= i_rd;
        o_retire_data <= alu_res;
end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
        parameter int IMEM_AW = 6
) (
        input  logic                 clk,
        input  logic                 i_rst_n,
        input  logic                 i_run,
        input  logic                 i_halt,
        output logic [IMEM_AW-1:0]   o_pc,
        output logic                 o_fetch_valid,
        output logic                 o_halted
);

// Fetch control states
typedef enum logic [1:0] {
        ST_IDLE,
        ST_FETCH,
        ST_HALTED
} fetch_state_e;

fetch_state_e state;
logic         fetching;

// Fetching this cycle, a halt in decode stops it at once
assign fetching = (state == ST_FETCH) && !i_halt;

assign o_halted = (state == ST_HALTED);

always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
                state         <= ST_IDLE;
                o_pc          <= '0;
                o_fetch_valid <= 1'b0;
        end else if (!i_run) begin
                // Run dropped, back to idle at address 0
                state         <= ST_IDLE;
                o_pc          <= '0;
                o_fetch_valid <= 1'b0;
        end else begin
                // Word read this edge is valid only while fetching
                o_fetch_valid <= fetching;
                if (fetching) begin
                        o_pc <= o_pc + 1'b1;
                end
                case (state)
                        ST_IDLE: begin
                                state <= ST_FETCH;
                        end
                        ST_FETCH: begin
                                if (i_halt) begin
                                        state <= ST_HALTED;
                                end
                        end
                        default: begin
                                // Halted until run drops
                                state <= ST_HALTED;
                        end
                endcase
        end
end

endmodule

// File: instr_mem.sv
`timescale 1ns/1ps

module instr_mem #(
        parameter int IMEM_AW = 6
) (
        input  logic                 clk,
        input  logic                 i_we,
        input  logic [IMEM_AW-1:0]   i_waddr,
        input  logic [IMEM_AW-1:0]   i_raddr,
        input  pipe_pkg::word_t      i_wdata,
        output pipe_pkg::word_t      o_rdata
);

import pipe_pkg::*;

localparam int DEPTH = 2 ** IMEM_AW;

// Program storage
word_t mem [DEPTH];

// Load port write
always_ff @(posedge clk) begin
        if (i_we) begin
                mem[i_waddr] <= i_wdata;
        end
end

// Synchronous read, word valid one cycle after the address
always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
end

endmodule

// File: isa_pkg.sv
package isa_pkg;

////////////////////////////////////////////////////////////
// Major opcodes
////////////////////////////////////////////////////////////

// Only the three major opcodes of the supported subset
typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
} opcode_e;

// ALU operations, PASS_B forwards operand B untouched (LUI)
typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_PASS_B
} alu_op_e;

////////////////////////////////////////////////////////////
// Function codes
////////////////////////////////////////////////////////////

localparam logic [2:0] F3_ADD_SUB = 3'b000;
localparam logic [2:0] F3_SLL     = 3'b001;
localparam logic [2:0] F3_SLT     = 3'b010;
localparam logic [2:0] F3_XOR     = 3'b100;
localparam logic [2:0] F3_SRL     = 3'b101;
localparam logic [2:0] F3_OR      = 3'b110;
localparam logic [2:0] F3_AND     = 3'b111;

// Base funct7, and the alternate one (SUB, SRA)
localparam logic [6:0] F7_BASE = 7'b0000000;
localparam logic [6:0] F7_ALT  = 7'b0100000;

////////////////////////////////////////////////////////////
// Field positions
////////////////////////////////////////////////////////////

localparam int OPC_LSB = 0;
localparam int OPC_MSB = 6;
localparam int RD_LSB  = 7;
localparam int RD_MSB  = 11;
localparam int F3_LSB  = 12;
localparam int F3_MSB  = 14;
localparam int RS1_LSB = 15;
localparam int RS1_MSB = 19;
localparam int RS2_LSB = 20;
localparam int RS2_MSB = 24;
localparam int F7_LSB  = 25;
localparam int F7_MSB  = 31;

// Immediate fields, both run up to bit 31
localparam int IMM_I_LSB = 20;
localparam int IMM_U_LSB = 12;

endpackage

// File: list.f
isa_pkg.sv
pipe_pkg.sv
instr_mem.sv
fetch_unit.sv
decoder.sv
register_file.sv
execute_stage.sv
core_top.sv
tb_checker.sv
tb_top.sv

// File: pipe_pkg.sv
package pipe_pkg;

// Datapath width
localparam int XLEN = 32;

// One data or instruction word
typedef logic [XLEN-1:0] word_t;

// Register file size and index
localparam int NUM_REGS = 32;
typedef logic [4:0] reg_idx_t;

// Shift amount bits taken from operand B
localparam int SHAMT_W = 5;

// Operand source in execute
typedef enum logic {
        FROM_REGFILE,
        FROM_WB
} fwd_sel_e;

endpackage

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
        input  logic                 clk,
        input  logic                 i_rst_n,
        input  logic                 i_we,
        input  pipe_pkg::reg_idx_t   i_waddr,
        input  pipe_pkg::reg_idx_t   i_raddr1,
        input  pipe_pkg::reg_idx_t   i_raddr2,
        input  pipe_pkg::word_t      i_wdata,
        output pipe_pkg::word_t      o_rdata1,
        output pipe_pkg::word_t      o_rdata2
);

import pipe_pkg::*;

// Architectural registers
word_t regs [NUM_REGS];

// Single write port, x0 never written
always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
                for (int i = 0; i < NUM_REGS; i++) begin
                        regs[i] <= '0;
                end
        end else if (i_we && (i_waddr != '0)) begin
                regs[i_waddr] <= i_wdata;
        end
end

// Combinational reads
// x0 forced to zero on both ports
assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
        parameter int IMEM_AW = 6
) (
        input  logic                 clk,
        input  logic                 i_rst_n,
        input  logic                 i_prog_we,
        input  logic [IMEM_AW-1:0]   i_prog_addr,
        input  pipe_pkg::word_t      i_prog_data,
        input  logic                 i_run,
        input  logic                 i_retire_valid,
        input  pipe_pkg::reg_idx_t   i_retire_rd,
        input  pipe_pkg::word_t      i_retire_data,
        input  logic                 i_halted,
        output int                   o_errors,
        output int                   o_retires
);

import isa_pkg::*;
import pipe_pkg::*;

localparam int DEPTH = 2 ** IMEM_AW;

// Copy of the loaded program and the architectural model state
word_t program_copy [DEPTH];
word_t model_regs [NUM_REGS];
bit    running;
bit    halt_seen;
int    cycle;
int    next_idx;

////////////////////////////////////////////////////////////
// Reference model of the subset
////////////////////////////////////////////////////////////

function automatic word_t model_result(input word_t w, input word_t a, input word_t b);
        logic [6:0] opc;
        logic [2:0] f3;
        word_t      rhs;
        word_t      res;
        opc = w[OPC_MSB:OPC_LSB];
        f3  = w[F3_MSB:F3_LSB];
        // I-type takes the sign-extended 12-bit field as rhs
        rhs = (opc == OPC_OP_IMM) ? {{20{w[31]}}, w[31:IMM_I_LSB]} : b;
        res = '0;
        if (opc == OPC_LUI) begin
                res = {w[31:IMM_U_LSB], 12'h000};
        end else begin
                case (f3)
                        F3_ADD_SUB: begin
                                // Alternate funct7 means SUB for R-type only
                                if (opc == OPC_OP && w[F7_MSB:F7_LSB] == F7_ALT) begin
                                        res = a - rhs;
                                end else begin
                                        res = a + rhs;
                                end
                        end
                        F3_SLL:  res = a << rhs[4:0];
                        F3_SLT:  res = ($signed(a) < $signed(rhs)) ? 32'd1 : 32'd0;
                        F3_XOR:  res = a ^ rhs;
                        F3_SRL:  res = a >> rhs[4:0];
                        F3_OR:   res = a | rhs;
                        F3_AND:  res = a & rhs;
                        default: res = '0;
                endcase
        end
        return res;
endfunction

////////////////////////////////////////////////////////////
// Per-event checks
////////////////////////////////////////////////////////////

task automatic compare_retire();
        word_t    w;
        word_t    exp;
        reg_idx_t rd;
        w = (next_idx < DEPTH) ? program_copy[next_idx] : '0;
        if (halt_seen) begin
                $display("Retire seen after the halt, rd %0d", i_retire_rd);
                o_errors++;
        end else if (w == '0) begin
                $display("Retire seen beyond the end of the program, rd %0d", i_retire_rd);
                o_errors++;
        end else begin
                // Without stalls retire k lands on a fixed cycle
                if (cycle != next_idx + 3) begin
                        $display("Retire %0d came on cycle %0d instead of cycle %0d",
                                 next_idx, cycle, next_idx + 3);
                        o_errors++;
                end
                rd  = w[RD_MSB:RD_LSB];
                exp = model_result(w, model_regs[w[RS1_MSB:RS1_LSB]],
                                   model_regs[w[RS2_MSB:RS2_LSB]]);
                if (i_retire_rd !== rd) begin
                        $display("FAILED o_retire_rd: expected %h, got %h", rd, i_retire_rd);
                        o_errors++;
                end
                if (i_retire_data !== exp) begin
                        $display("FAILED o_retire_data: expected %h, got %h", exp, i_retire_data);
                        o_errors++;
                end
                // x0 stays zero in the model
                if (rd != '0) begin
                        model_regs[rd] = exp;
                end
                next_idx++;
        end
        o_retires++;
endtask

task automatic verify_halt();
        halt_seen = 1'b1;
        if (cycle != next_idx + 3) begin
                $display("Halt came on cycle %0d instead of cycle %0d", cycle, next_idx + 3);
                o_errors++;
        end
        if (next_idx < DEPTH && program_copy[next_idx] != '0) begin
                $display("Halt came after %0d retires, before the end of the program", next_idx);
                o_errors++;
        end
endtask

// Outputs read here are those of the previous edge
always @(posedge clk) begin
        if (!i_rst_n) begin
                for (int i = 0; i < NUM_REGS; i++) begin
                        model_regs[i] = '0;
                end
                running   = 1'b0;
                halt_seen = 1'b0;
                cycle     = 0;
                next_idx  = 0;
                o_errors  = 0;
                o_retires = 0;
        end else begin
                // Snoop the load port
                if (i_prog_we) begin
                        program_copy[i_prog_addr] = i_prog_data;
                end
                if (!i_run || !running) begin
                        if (i_retire_valid) begin
                                $display("Retire seen while the core was not running");
                                o_errors++;
                        end
                        // First edge with run high counts as cycle 0
                        running   = i_run;
                        halt_seen = 1'b0;
                        cycle     = 0;
                        next_idx  = 0;
                end else begin
                        cycle++;
                        if (i_retire_valid) begin
                                compare_retire();
                        end
                        if (i_halted && !halt_seen) begin
                                verify_halt();
                        end
                end
        end
end

endmodule

// File: tb_top.sv
`timescale 1ns/1ps

module tb_top;

import isa_pkg::*;
import pipe_pkg::*;

localparam int IMEM_AW    = 6;
localparam int WAIT_LIMIT = 200;
localparam int NUM_TESTS  = 6;

// Program styles
localparam int MODE_R     = 0;
localparam int MODE_I     = 1;
localparam int MODE_CHAIN = 2;
localparam int MODE_X0    = 3;
localparam int MODE_MIX   = 4;

localparam int TEST_MODE [NUM_TESTS] = '{MODE_I, MODE_R, MODE_CHAIN, MODE_X0, MODE_MIX, MODE_MIX};
localparam int TEST_LEN  [NUM_TESTS] = '{40, 48, 50, 40, 20, 62};

// Index 1 pairs with the alternate funct7 (SUB)
localparam logic [2:0] R_F3 [8] = '{F3_ADD_SUB, F3_ADD_SUB, F3_SLL, F3_SLT,
                                    F3_XOR, F3_SRL, F3_OR, F3_AND};
localparam logic [2:0] I_F3 [4] = '{F3_ADD_SUB, F3_XOR, F3_OR, F3_AND};

logic               clk;
logic               rst_n;
logic               prog_we;
logic [IMEM_AW-1:0] prog_addr;
word_t              prog_data;
logic               run;
logic               retire_valid;
reg_idx_t           retire_rd;
word_t              retire_data;
logic               halted;
int                 chk_errors;
int                 chk_retires;

logic [31:0] rng_state;
word_t       prog [$];
int          tests_bad;
bit          timed_out;

core_top #(
        .IMEM_AW(IMEM_AW)
) dut_i (
        .clk(clk),
        .i_rst_n(rst_n),
        .i_prog_we(prog_we),
        .i_prog_addr(prog_addr),
        .i_prog_data(prog_data),
        .i_run(run),
        .o_retire_valid(retire_valid),
        .o_retire_rd(retire_rd),
        .o_retire_data(retire_data),
        .o_halted(halted)
);

tb_checker #(
        .IMEM_AW(IMEM_AW)
) checker_i (
        .clk(clk),
        .i_rst_n(rst_n),
        .i_prog_we(prog_we),
        .i_prog_addr(prog_addr),
        .i_prog_data(prog_data),
        .i_run(run),
        .i_retire_valid(retire_valid),
        .i_retire_rd(retire_rd),
        .i_retire_data(retire_data),
        .i_halted(halted),
        .o_errors(chk_errors),
        .o_retires(chk_retires)
);

// 8 ns clock
always #4 clk = ~clk;

////////////////////////////////////////////////////////////
// Random program generation
////////////////////////////////////////////////////////////

function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
endfunction

function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
endfunction

task automatic gen_program(input int mode, input int len);
        logic [31:0] r;
        logic [31:0] u;
        logic [6:0]  f7;
        logic [2:0]  kind;
        logic [2:0]  sel;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    prev1;
        reg_idx_t    prev2;
        prog.delete();
        prev1 = 5'd1;
        prev2 = 5'd2;
        for (int k = 0; k < len; k++) begin
                r    = next_rand();
                u    = next_rand();
                rd   = r[4:0];
                rs1  = r[9:5];
                rs2  = r[14:10];
                // Kind 0 to 4 R-type, 5 and 6 I-type, 7 LUI
                kind = r[17:15];
                sel  = r[20:18];
                // R-type only, operands come from the previous test
                if (mode == MODE_R && kind >= 3'd5) begin
                        kind = 3'd0;
                end
                if (mode == MODE_I) begin
                        kind = (r[16:15] == 2'b00) ? 3'd7 : 3'd5;
                end
                // Each rd feeds rs1 next and rs2 two later
                if (mode == MODE_CHAIN) begin
                        if (rd == '0) begin
                                rd = 5'd31;
                        end
                        rs1 = prev1;
                        rs2 = prev2;
                end
                // Crowd into x0 to x3
                if (mode == MODE_X0) begin
                        rd  = {3'b000, rd[1:0]};
                        rs1 = {3'b000, rs1[1:0]};
                        rs2 = {3'b000, rs2[1:0]};
                end
                f7 = (sel == 3'd1) ? F7_ALT : F7_BASE;
                if (kind < 3'd5) begin
                        prog.push_back({f7, rs2, rs1, R_F3[sel], rd, OPC_OP});
                end else if (kind < 3'd7) begin
                        prog.push_back({u[11:0], rs1, I_F3[sel[1:0]], rd, OPC_OP_IMM});
                end else begin
                        prog.push_back({u[31:12], rd, OPC_LUI});
                end
                prev2 = prev1;
                prev1 = rd;
        end
        // Halt word
        prog.push_back('0);
endtask

////////////////////////////////////////////////////////////
// Load and run
////////////////////////////////////////////////////////////

task automatic load_program();
        for (int a = 0; a < prog.size(); a++) begin
                @(negedge clk);
                prog_we   = 1'b1;
                prog_addr = a[IMEM_AW-1:0];
                prog_data = prog[a];
        end
        @(negedge clk);
        prog_we = 1'b0;
endtask

task automatic run_test(input int idx);
        int errs_before;
        int rets_before;
        int waited;
        int rets;
        bit bad;
        gen_program(TEST_MODE[idx], TEST_LEN[idx]);
        load_program();
        errs_before = chk_errors;
        rets_before = chk_retires;
        run         = 1'b1;
        waited      = 0;
        while (!halted && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
        end
        if (!halted) begin
                $display("Timeout in test %0d, o_halted did not rise", idx);
                timed_out = 1'b1;
                return;
        end
        // Quiet window in which nothing may retire after the halt
        repeat (3) @(negedge clk);
        run    = 1'b0;
        waited = 0;
        while (halted && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
        end
        if (halted) begin
                $display("Timeout in test %0d, o_halted stayed high after run dropped", idx);
                timed_out = 1'b1;
                return;
        end
        rets = chk_retires - rets_before;
        bad  = (chk_errors != errs_before);
        if (rets != TEST_LEN[idx]) begin
                $display("Test %0d saw %0d retires for %0d instructions", idx, rets, TEST_LEN[idx]);
                bad = 1'b1;
        end
        if (bad) begin
                tests_bad++;
        end
        $display("test %0d mode %0d: %0d instructions, %0d retires, %s",
                 idx, TEST_MODE[idx], TEST_LEN[idx], rets, bad ? "failed" : "ok");
endtask

initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        run       = 1'b0;
        rng_state = 32'hdeb3_adb7;
        tests_bad = 0;
        timed_out = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
                run_test(t);
        end
        $display("tests %0d, failed tests %0d, failed checks %0d, retires %0d",
                 NUM_TESTS, tests_bad, chk_errors, chk_retires);
        if (timed_out || tests_bad != 0 || chk_errors != 0) begin
                $display("TESTBENCH FAILED");
        end else begin
                $display("TESTBENCH PASSED");
        end
        $finish;
end

endmodule
